// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_STR  ?= TEST PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
src/lsu_pkg.sv
src/lsu_request_decode.sv
src/wb_data_master.sv
src/load_align.sv
src/lsu_top.sv
verification/lsu_tb.sv

// ==== src/load_align.sv ====
module load_align
  import lsu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            clear_i,
  input  wb_rsp_t         rsp_i,
  input  logic            rsp_valid_i,
  output logic [XLEN-1:0] rdata_o,
  output logic            done_o,
  output logic            pending_o
);

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] ext;
  logic            is_load;

  // Addressed byte moved down to lane 0
  assign shifted = rsp_i.dat >> {rsp_i.offset, 3'b000};
  assign is_load = !rsp_i.op[3];

  always_comb begin
    case (rsp_i.op)
      LB:      ext = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      LBU:     ext = {{(XLEN-8){1'b0}}, shifted[7:0]};
      LH:      ext = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      LHU:     ext = {{(XLEN-16){1'b0}}, shifted[15:0]};
      default: ext = rsp_i.dat;  // LW, stores never reach rdata_o
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else if (clear_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= rsp_valid_i;
    end
  end

  // Result held until the next load completes
  always_ff @(posedge clk_i) begin
    if (rsp_valid_i && is_load) begin
      rdata_o <= ext;
    end
  end

  // Covers the response cycle and the done cycle
  assign pending_o = rsp_valid_i || done_o;

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

  // Data path and address width
  localparam int XLEN  = 32;
  localparam int BE_W  = XLEN / 8;       // Byte lanes per word
  localparam int ADR_W = XLEN - 2;       // Word address on the bus
  localparam int OFF_W = 2;              // Byte offset inside a word

  // RV32 funct3 coding, bit 3 set for stores
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } mem_op_e;

  // Decoded request for the bus master
  typedef struct packed {
    logic [ADR_W-1:0] adr;
    logic [BE_W-1:0]  sel;
    logic [XLEN-1:0]  dat;         // Store data already replicated into lanes
    logic             we;
    logic             misaligned;
    mem_op_e          op;
    logic [OFF_W-1:0] offset;
  } wb_req_t;

  // Raw read word plus what the align stage needs
  typedef struct packed {
    logic [XLEN-1:0]  dat;
    mem_op_e          op;
    logic [OFF_W-1:0] offset;
  } wb_rsp_t;

endpackage

// ==== src/lsu_request_decode.sv ====
module lsu_request_decode
  import lsu_pkg::*;
(
  input  mem_op_e         op_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output wb_req_t         req_o
);

  logic [OFF_W-1:0] offset;
  logic [1:0]       size;      // 0 byte, 1 half, 2 word
  logic [BE_W-1:0]  sel;
  logic [XLEN-1:0]  lane_dat;
  logic             misaligned;

  assign offset = addr_i[OFF_W-1:0];
  assign size   = op_i[1:0];

  // Byte selects from access size and low address bits
  always_comb begin
    case (size)
      2'b00: sel = BE_W'(1) << offset;
      2'b01: sel = {{2{offset[1]}}, {2{~offset[1]}}};  // Upper or lower pair
      default: sel = '1;
    endcase
  end

  // Store data copied into every lane it could land in
  always_comb begin
    case (size)
      2'b00: lane_dat = {BE_W{wdata_i[7:0]}};
      2'b01: lane_dat = {(BE_W/2){wdata_i[15:0]}};
      default: lane_dat = wdata_i;
    endcase
  end

  // Half-word on odd byte, word off a 4-byte boundary
  always_comb begin
    case (size)
      2'b00: misaligned = 1'b0;
      2'b01: misaligned = offset[0];
      default: misaligned = |offset;
    endcase
  end

  always_comb begin
    req_o.adr        = addr_i[XLEN-1:OFF_W];
    req_o.sel        = sel;
    req_o.dat        = lane_dat;
    req_o.we         = op_i[3];  // Store opcodes have the top bit set
    req_o.misaligned = misaligned;
    req_o.op         = op_i;
    req_o.offset     = offset;
  end

endmodule

// ==== src/lsu_top.sv ====
module lsu_top
  import lsu_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Core side
  input  logic             start_i,
  input  mem_op_e          op_i,
  input  logic [XLEN-1:0]  addr_i,
  input  logic [XLEN-1:0]  wdata_i,
  input  logic             clear_i,
  output logic             busy_o,
  output logic             done_o,
  output logic [XLEN-1:0]  rdata_o,
  output logic             err_o,

  // Wishbone side
  output logic [ADR_W-1:0] wb_adr_o,
  output logic [XLEN-1:0]  wb_dat_o,
  output logic [BE_W-1:0]  wb_sel_o,
  output logic             wb_we_o,
  output logic             wb_stb_o,
  output logic             wb_cyc_o,
  input  logic [XLEN-1:0]  wb_dat_i,
  input  logic             wb_ack_i,
  input  logic             wb_err_i
);

  wb_req_t req;
  wb_rsp_t rsp;
  logic    rsp_valid;
  logic    master_busy;
  logic    align_pending;

  // Refuse a start while either stage still owns a request
  assign busy_o = master_busy || align_pending;

  lsu_request_decode u_decode (
    .op_i    (op_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .req_o   (req)
  );

  wb_data_master u_master (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .start_i     (start_i && !busy_o),
    .req_i       (req),
    .busy_o      (master_busy),
    .err_o       (err_o),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_sel_o    (wb_sel_o),
    .wb_we_o     (wb_we_o),
    .wb_stb_o    (wb_stb_o),
    .wb_cyc_o    (wb_cyc_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .wb_err_i    (wb_err_i)
  );

  load_align u_align (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .rsp_i       (rsp),
    .rsp_valid_i (rsp_valid),
    .rdata_o     (rdata_o),
    .done_o      (done_o),
    .pending_o   (align_pending)
  );

endmodule

// ==== src/wb_data_master.sv ====
module wb_data_master
  import lsu_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             clear_i,
  input  logic             start_i,
  input  wb_req_t          req_i,
  output logic             busy_o,
  output logic             err_o,
  output wb_rsp_t          rsp_o,
  output logic             rsp_valid_o,

  // Wishbone classic master
  output logic [ADR_W-1:0] wb_adr_o,
  output logic [XLEN-1:0]  wb_dat_o,
  output logic [BE_W-1:0]  wb_sel_o,
  output logic             wb_we_o,
  output logic             wb_stb_o,
  output logic             wb_cyc_o,
  input  logic [XLEN-1:0]  wb_dat_i,
  input  logic             wb_ack_i,
  input  logic             wb_err_i
);

  typedef enum logic {
    ST_IDLE,
    ST_ACTIVE
  } state_e;

  state_e           state;
  logic             accept;
  logic             launch;
  logic             ack_seen;
  logic [XLEN-1:0]  rdat_q;
  mem_op_e          op_q;
  logic [OFF_W-1:0] off_q;

  // A sticky error holds off new requests until cleared
  assign accept   = start_i && (state == ST_IDLE) && !err_o;
  assign launch   = accept && !req_i.misaligned;
  assign ack_seen = (state == ST_ACTIVE) && wb_ack_i;

  assign busy_o   = (state == ST_ACTIVE);
  assign wb_stb_o = (state == ST_ACTIVE);
  assign wb_cyc_o = wb_stb_o;              // Single master, cyc follows stb

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state       <= ST_IDLE;
      wb_sel_o    <= '0;
      wb_we_o     <= 1'b0;
      err_o       <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else if (clear_i) begin
      state       <= ST_IDLE;
      wb_sel_o    <= '0;
      wb_we_o     <= 1'b0;
      err_o       <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept && req_i.misaligned) begin
            err_o <= 1'b1;               // No bus cycle for this one
          end else if (launch) begin
            state    <= ST_ACTIVE;
            wb_sel_o <= req_i.sel;
            wb_we_o  <= req_i.we;
          end
        end
        ST_ACTIVE: begin
          if (wb_ack_i) begin
            state       <= ST_IDLE;
            wb_we_o     <= 1'b0;
            rsp_valid_o <= 1'b1;
          end else if (wb_err_i) begin
            state    <= ST_IDLE;
            wb_sel_o <= '0;
            wb_we_o  <= 1'b0;
            err_o    <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address, data and tag registers
  always_ff @(posedge clk_i) begin
    if (launch) begin
      wb_adr_o <= req_i.adr;
      wb_dat_o <= req_i.dat;
      op_q     <= req_i.op;
      off_q    <= req_i.offset;
    end
    if (ack_seen) begin
      rdat_q <= wb_dat_i;
    end
  end

  assign rsp_o = '{dat: rdat_q, op: op_q, offset: off_q};

endmodule

// ==== verification/lsu_tb.sv ====
module lsu_tb
  import lsu_pkg::*;
();

  localparam int NUM_TX     = 300;
  localparam int CLK_PERIOD = 8;
  localparam int MEM_WORDS  = 64;
  localparam int ERR_BASE   = 56;        // Words 56..63 answer with a bus error
  localparam int ACCESS_MAX = 20;        // Cycles allowed for one access
  localparam longint WATCHDOG_TIME = longint'(NUM_TX) * 10 * CLK_PERIOD;

  logic             clk_i;
  logic             rst_n_i;
  logic             start_i;
  mem_op_e          op_i;
  logic [XLEN-1:0]  addr_i;
  logic [XLEN-1:0]  wdata_i;
  logic             clear_i;
  logic             busy_o;
  logic             done_o;
  logic [XLEN-1:0]  rdata_o;
  logic             err_o;
  logic [ADR_W-1:0] wb_adr_o;
  logic [XLEN-1:0]  wb_dat_o;
  logic [BE_W-1:0]  wb_sel_o;
  logic             wb_we_o;
  logic             wb_stb_o;
  logic             wb_cyc_o;
  logic [XLEN-1:0]  wb_dat_i = '0;
  logic             wb_ack_i = 1'b0;
  logic             wb_err_i = 1'b0;

  int              seed = 6;
  int              done_cnt = 0;
  int              exp_done = 0;
  logic [XLEN-1:0] mem    [MEM_WORDS];   // Slave memory
  logic [XLEN-1:0] mirror [MEM_WORDS];   // Reference copy
  logic [XLEN-1:0] exp_adr;
  logic [BE_W-1:0] exp_sel;
  logic [XLEN-1:0] exp_lanes;
  logic            exp_we;
  int              wait_left;
  bit              in_cycle = 1'b0;

  mem_op_e all_ops   [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
  mem_op_e misal_ops [5] = '{LH, LHU, SH, LW, SW};

  lsu_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired, the DUT hung");
    $display("TEST FAILED");
    $fatal(1);
  end

  // Counts every done pulse including unexpected ones
  always @(negedge clk_i) begin
    if (done_o) done_cnt++;
  end

  function automatic logic [XLEN-1:0] fill_word(int i);
    return XLEN'(32'h9E37_79B9 * (i + 1)) ^ XLEN'(i << 20);
  endfunction

  // Lanes covered by the access, starting at the offset
  function automatic logic [BE_W-1:0] sel_for(mem_op_e op, logic [1:0] off);
    logic [BE_W-1:0] s;
    int              bytes;
    bytes = 1 << op[1:0];
    s     = '0;
    for (int b = 0; b < BE_W; b++) begin
      if (b >= int'(off) && b < int'(off) + bytes) s[b] = 1'b1;
    end
    return s;
  endfunction

  function automatic logic [XLEN-1:0] lane_mask(logic [BE_W-1:0] sel);
    logic [XLEN-1:0] m;
    m = '0;
    for (int b = 0; b < BE_W; b++) begin
      if (sel[b]) m[8*b +: 8] = 8'hFF;
    end
    return m;
  endfunction

  // Store data moved to the lanes named by the offset
  function automatic logic [XLEN-1:0] store_lanes(mem_op_e op, logic [1:0] off,
                                                  logic [XLEN-1:0] wdata);
    case (op[1:0])
      2'b00:   return XLEN'(wdata[7:0]) << {off, 3'b000};
      2'b01:   return XLEN'(wdata[15:0]) << {off, 3'b000};
      default: return wdata;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] load_value(mem_op_e op, logic [1:0] off,
                                                 logic [XLEN-1:0] word);
    logic [XLEN-1:0] s;
    s = word >> (8 * off);
    case (op)
      LB:      return {{24{s[7]}}, s[7:0]};
      LBU:     return {24'h0, s[7:0]};
      LH:      return {{16{s[15]}}, s[15:0]};
      LHU:     return {16'h0, s[15:0]};
      default: return word;
    endcase
  endfunction

  function automatic bit is_misaligned(mem_op_e op, logic [1:0] off);
    if (op[1:0] == 2'b01) return off[0];
    if (op[1:0] == 2'b10) return |off;
    return 1'b0;
  endfunction

  task automatic report_error(input string msg);
    $display("%s at time %0t", msg, $time);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_sel(input string name, input logic [BE_W-1:0] got,
                           input logic [BE_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_quiet();
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("err_o", err_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    check_flag("wb_stb_o", wb_stb_o, 1'b0);
    check_flag("wb_cyc_o", wb_cyc_o, 1'b0);
  endtask

  task automatic check_idle();
    check_quiet();
    check_flag("wb_we_o", wb_we_o, 1'b0);
    check_sel("wb_sel_o", wb_sel_o, '0);
  endtask

  task automatic clear_pulse();
    @(posedge clk_i);
    #1 clear_i = 1'b1;
    @(posedge clk_i);
    #1 clear_i = 1'b0;
    @(negedge clk_i);
    check_idle();
  endtask

  // Wishbone slave with memory loaded while reset is low
  always @(posedge clk_i) begin
    int idx;
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
      in_cycle = 1'b0;
    end else if (wb_ack_i || wb_err_i) begin
      #1;
      wb_ack_i = 1'b0;
      wb_err_i = 1'b0;
    end else if (wb_stb_o && wb_cyc_o) begin
      if (!in_cycle) begin
        in_cycle  = 1'b1;
        wait_left = int'($unsigned($random(seed)) % 4);
      end
      if (wait_left == 0) begin
        in_cycle = 1'b0;
        check_word("wb_adr_o", {2'b00, wb_adr_o}, exp_adr);
        check_sel("wb_sel_o", wb_sel_o, exp_sel);
        check_flag("wb_we_o", wb_we_o, exp_we);
        if (exp_we) begin
          check_word("wb_dat_o", wb_dat_o & lane_mask(exp_sel),
                     exp_lanes & lane_mask(exp_sel));
        end
        idx = int'(wb_adr_o[5:0]);
        #1;
        if (idx >= ERR_BASE) begin
          wb_err_i = 1'b1;
          wb_dat_i = 32'hDEAD_BEEF;
        end else begin
          for (int b = 0; b < BE_W; b++) begin
            if (wb_we_o && wb_sel_o[b]) mem[idx][8*b +: 8] = wb_dat_o[8*b +: 8];
          end
          wb_dat_i = mem[idx];
          wb_ack_i = 1'b1;
        end
      end else begin
        wait_left--;
      end
    end
  end

  task automatic run_access(input mem_op_e op, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] wdata, input bit inject);
    logic [1:0] off;
    int         idx;
    bit         misal;
    bit         bus_err;
    int         cycles;
    off     = addr[1:0];
    idx     = int'(addr[7:2]);
    misal   = is_misaligned(op, off);
    bus_err = !misal && (idx >= ERR_BASE);
    exp_adr   = {2'b00, addr[XLEN-1:2]};
    exp_sel   = sel_for(op, off);
    exp_lanes = store_lanes(op, off, wdata);
    exp_we    = op[3];
    @(posedge clk_i);
    #1;
    start_i = 1'b1;
    op_i    = op;
    addr_i  = addr;
    wdata_i = wdata;
    @(posedge clk_i);
    #1;
    if (inject && !misal) begin  // Junk start held while busy_o is high
      op_i    = all_ops[$unsigned($random(seed)) % 8];
      addr_i  = XLEN'($unsigned($random(seed)) % 256);
      wdata_i = $random(seed);
      if (bus_err) begin
        @(posedge clk_i);  // Held one cycle since the error drops busy_o
        #1;
        start_i = 1'b0;
      end
    end else begin
      start_i = 1'b0;
    end
    if (misal) begin
      repeat (3) begin
        @(negedge clk_i);
        check_flag("err_o", err_o, 1'b1);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("wb_stb_o", wb_stb_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
      end
      clear_pulse();
    end else if (bus_err) begin
      cycles = 0;
      do begin
        @(negedge clk_i);
        check_flag("done_o", done_o, 1'b0);
        cycles++;
        if (cycles > ACCESS_MAX) report_error("Bus error never raised err_o");
      end while (!err_o);
      repeat (2) begin
        @(negedge clk_i);
        check_flag("err_o", err_o, 1'b1);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("wb_stb_o", wb_stb_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
      end
      clear_pulse();
    end else begin
      cycles = 0;
      do begin
        @(negedge clk_i);
        check_flag("busy_o", busy_o, 1'b1);
        cycles++;
        if (cycles > ACCESS_MAX) report_error("Access never finished with done_o");
      end while (!done_o);
      check_flag("err_o", err_o, 1'b0);
      exp_done++;
      if (!op[3]) begin
        check_word("rdata_o", rdata_o, load_value(op, off, mirror[idx]));
      end else begin
        for (int b = 0; b < BE_W; b++) begin
          if (exp_sel[b]) mirror[idx][8*b +: 8] = exp_lanes[8*b +: 8];
        end
      end
      if (inject) begin
        @(posedge clk_i);  // Junk start still seen while done_o holds busy_o
        #1 start_i = 1'b0;
      end
    end
  endtask

  initial begin
    mem_op_e         op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    int              r;
    bit              inject;
    rst_n_i = 1'b0;
    start_i = 1'b0;
    clear_i = 1'b0;
    op_i    = LW;
    addr_i  = '0;
    wdata_i = '0;
    for (int i = 0; i < MEM_WORDS; i++) mirror[i] = fill_word(i);
    repeat (2) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle();
    for (int n = 0; n < NUM_TX; n++) begin
      r     = int'($unsigned($random(seed)) % 100);
      wdata = $random(seed);
      if (r < 10) begin
        op   = misal_ops[$unsigned($random(seed)) % 5];
        addr = XLEN'($unsigned($random(seed)) % 256);
        if (op[1:0] == 2'b01) addr[0] = 1'b1;
        else if (addr[1:0] == 2'b00) addr[1:0] = 2'b01;
      end else begin
        op = all_ops[$unsigned($random(seed)) % 8];
        if (r < 18) addr = XLEN'(224 + $unsigned($random(seed)) % 32);
        else addr = XLEN'($unsigned($random(seed)) % 224);
        if (op[1:0] == 2'b01) addr[0] = 1'b0;
        if (op[1:0] == 2'b10) addr[1:0] = 2'b00;
      end
      inject = ($unsigned($random(seed)) % 4) == 0;
      run_access(op, addr, wdata, inject);
    end
    repeat (2) @(negedge clk_i);
    check_quiet();
    check_word("done count", XLEN'(done_cnt), XLEN'(exp_done));
    for (int i = 0; i < MEM_WORDS; i++) check_word("memory word", mem[i], mirror[i]);
    $display("TEST PASSED");
    $finish;
  end

endmodule
